// ==== common/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Boot vector in kseg1 where the first fetch starts.
`define CFG_RESET_PC 32'hbfc00000

// Entries in the reorder buffer. The tag counter wraps at this depth.
`define CFG_ROB_DEPTH 16

`define CFG_TAG_W 4

`endif

// ==== common/isa_pkg.sv ====
package isa_pkg;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_REGIMM  = 6'h01,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_BLEZ    = 6'h06,
    OP_BGTZ    = 6'h07,
    OP_ADDI    = 6'h08,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_SLTIU   = 6'h0b,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LB      = 6'h20,
    OP_LH      = 6'h21,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_LHU     = 6'h25,
    OP_SB      = 6'h28,
    OP_SH      = 6'h29,
    OP_SW      = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    FN_SLL     = 6'h00,
    FN_SRL     = 6'h02,
    FN_SRA     = 6'h03,
    FN_JR      = 6'h08,
    FN_JALR    = 6'h09,
    FN_SYSCALL = 6'h0c,
    FN_ADD     = 6'h20,
    FN_ADDU    = 6'h21,
    FN_SUB     = 6'h22,
    FN_SUBU    = 6'h23,
    FN_AND     = 6'h24,
    FN_OR      = 6'h25,
    FN_XOR     = 6'h26,
    FN_NOR     = 6'h27,
    FN_SLT     = 6'h2a,
    FN_SLTU    = 6'h2b
  } funct_e;

  // Branch codes held in the rt field under OP_REGIMM.
  typedef enum logic [4:0] {
    RI_BLTZ = 5'h00,
    RI_BGEZ = 5'h01
  } regimm_e;

  typedef enum logic [1:0] {
    EXC_NONE    = 2'd0,
    EXC_RI      = 2'd1,
    EXC_SYSCALL = 2'd2
  } exc_type_e;

endpackage

// ==== common/uarch_pkg.sv ====
`include "cpu_config.svh"

package uarch_pkg;

  import isa_pkg::*;

  typedef logic [31:0]           word_t;
  typedef logic [31:0]           addr_t;
  typedef logic [4:0]            reg_idx_t;
  typedef logic [`CFG_TAG_W-1:0] rob_tag_t;
  typedef logic [3:0]            mem_sel_t;

  typedef struct packed {
    addr_t pc;
    word_t inst;
  } fetch_slot_t;

  typedef struct packed {
    rob_tag_t   tag;
    addr_t      pc;
    logic [5:0] funct;
    logic [4:0] shamt;
    logic       operand_is_ref_1;
    logic       operand_is_ref_2;
    word_t      operand_data_1;
    word_t      operand_data_2;
    logic       reg_write_en;
    reg_idx_t   reg_write_addr;
    logic       mem_read;
    logic       mem_write;
    logic       mem_sign_ext;
    mem_sel_t   mem_sel;
    logic       is_branch;
    logic       is_jump;
    addr_t      branch_target;
    logic       is_delayslot;
    exc_type_e  exc_type;
  } decode_slot_t;

endpackage

// ==== src/inst_fetch.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module inst_fetch
  import uarch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  redirect_en,
  input  addr_t redirect_pc,
  input  logic  slot_free,
  output logic  wb_cyc,
  output logic  wb_stb,
  output addr_t wb_adr,
  input  word_t wb_dat,
  input  logic  wb_ack,
  output logic  fetch_valid,
  output addr_t fetch_pc,
  output word_t fetch_word
);

  addr_t next_pc;
  logic  cyc_q;
  logic  stale_q;

  assign wb_cyc      = cyc_q;
  assign wb_stb      = cyc_q;
  assign fetch_valid = cyc_q && wb_ack && !stale_q && !redirect_en;
  assign fetch_pc    = wb_adr;
  assign fetch_word  = wb_dat;

  always_ff @(posedge clk) begin
    if (!rst) begin
      cyc_q   <= 1'b0;
      stale_q <= 1'b0;
      next_pc <= `CFG_RESET_PC;
    end else begin
      if (cyc_q) begin
        if (wb_ack) begin
          cyc_q   <= 1'b0;
          stale_q <= 1'b0;
          if (!stale_q) next_pc <= wb_adr + 32'd4;
        end else if (redirect_en) begin
          stale_q <= 1'b1; // The word of this cycle is dropped when it arrives.
        end
      end else if (slot_free && !redirect_en) begin
        cyc_q <= 1'b1;
      end
      if (redirect_en) next_pc <= redirect_pc;
    end
  end

  // Address follows next_pc while idle and freezes for the whole bus cycle.
  always_ff @(posedge clk) begin
    if (!cyc_q) wb_adr <= next_pc;
  end

endmodule

// ==== src/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     flush,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  assign in_ready = (!out_valid || out_ready) && !flush; // Free, or draining this cycle.

  always_ff @(posedge clk) begin
    if (!rst) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) out_data <= in_data;
  end

endmodule

// ==== src/front_ctrl.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module front_ctrl
  import uarch_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     redirect_en,
  input  logic     dec_fire,
  input  logic     dec_is_jump_or_branch,
  output logic     flush,
  output rob_tag_t alloc_tag,
  output logic     in_delayslot
);

  localparam rob_tag_t LAST_TAG = rob_tag_t'(`CFG_ROB_DEPTH - 1);

  rob_tag_t tag_q;
  logic     delay_q;

  assign flush        = redirect_en; // Both slots drop in the redirect cycle.
  assign alloc_tag    = tag_q;
  assign in_delayslot = delay_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      tag_q <= '0;
    end else if (dec_fire) begin
      tag_q <= (tag_q == LAST_TAG) ? '0 : tag_q + 1'b1;
    end
  end

  // Marks the instruction after a branch or jump as its delay slot.
  always_ff @(posedge clk) begin
    if (!rst) begin
      delay_q <= 1'b0;
    end else if (redirect_en) begin
      delay_q <= 1'b0;
    end else if (dec_fire) begin
      delay_q <= dec_is_jump_or_branch;
    end
  end

endmodule

// ==== decode/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder
  import isa_pkg::*;
  import uarch_pkg::*;
(
  input  addr_t      pc,
  input  word_t      inst,
  output reg_idx_t   rs_idx,
  output reg_idx_t   rt_idx,
  output logic [5:0] funct,
  output logic [4:0] shamt,
  output logic       reg_write_en,
  output reg_idx_t   reg_write_addr,
  output logic       mem_read,
  output logic       mem_write,
  output logic       mem_sign_ext,
  output mem_sel_t   mem_sel,
  output logic       is_branch,
  output logic       is_jump,
  output addr_t      branch_target,
  output exc_type_e  exc_type,
  output word_t      imm_val,
  output logic       use_imm,
  output logic       is_link
);

  logic [5:0] opcode;
  reg_idx_t   rt_field;
  reg_idx_t   rd_field;
  word_t      imm_sext;
  word_t      imm_zext;
  addr_t      branch_addr;
  addr_t      jump_addr;
  mem_sel_t   size_mask;

  assign opcode      = inst[31:26];
  assign rs_idx      = inst[25:21];
  assign rt_field    = inst[20:16];
  assign rd_field    = inst[15:11];
  assign imm_sext    = {{16{inst[15]}}, inst[15:0]};
  assign imm_zext    = {16'h0000, inst[15:0]};
  assign branch_addr = pc + 32'd4 + {imm_sext[29:0], 2'b00};
  assign jump_addr   = {pc[31:28], inst[25:0], 2'b00};

  // Opcode bits 27:26 give the access size for every load and store.
  assign size_mask = (inst[27:26] == 2'b00) ? 4'b0001 :
                     (inst[27:26] == 2'b01) ? 4'b0011 : 4'b1111;

  always_comb begin
    rt_idx         = rt_field;
    funct          = FN_ADDU;
    shamt          = '0;
    reg_write_en   = 1'b0;
    reg_write_addr = rt_field;
    mem_read       = 1'b0;
    mem_write      = 1'b0;
    mem_sign_ext   = 1'b0;
    mem_sel        = '0;
    is_branch      = 1'b0;
    is_jump        = 1'b0;
    branch_target  = '0;
    exc_type       = EXC_NONE;
    imm_val        = imm_sext;
    use_imm        = 1'b1;
    is_link        = 1'b0;
    case (opcode)
      OP_SPECIAL: begin
        use_imm        = 1'b0;
        funct          = inst[5:0];
        shamt          = inst[10:6];
        reg_write_addr = rd_field;
        case (inst[5:0])
          FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
          FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA: reg_write_en = 1'b1;
          FN_JR: is_jump = 1'b1;
          FN_JALR: begin
            is_jump      = 1'b1;
            is_link      = 1'b1;
            reg_write_en = 1'b1;
            rt_idx       = rs_idx; // Port 1 carries the link address, so the target comes on port 2.
          end
          FN_SYSCALL: exc_type = EXC_SYSCALL;
          default: exc_type = EXC_RI;
        endcase
      end
      OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
        reg_write_en = 1'b1;
        funct = (opcode == OP_ADDI)  ? FN_ADD  :
                (opcode == OP_ADDIU) ? FN_ADDU :
                (opcode == OP_SLTI)  ? FN_SLT  : FN_SLTU;
      end
      OP_ANDI, OP_ORI, OP_XORI: begin
        reg_write_en = 1'b1;
        imm_val      = imm_zext;
        funct = (opcode == OP_ANDI) ? FN_AND :
                (opcode == OP_ORI)  ? FN_OR  : FN_XOR;
      end
      OP_LUI: begin
        reg_write_en = 1'b1;
        funct        = FN_OR;
        imm_val      = {inst[15:0], 16'h0000};
      end
      OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
        reg_write_en = 1'b1;
        mem_read     = 1'b1;
        mem_sign_ext = (opcode == OP_LB) || (opcode == OP_LH);
        mem_sel      = size_mask;
      end
      OP_SB, OP_SH, OP_SW: begin
        mem_write     = 1'b1;
        mem_sel       = size_mask;
        use_imm       = 1'b0;
        branch_target = imm_sext; // Address offset of a store. Operand 2 holds the data.
      end
      OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
        is_branch     = 1'b1;
        use_imm       = 1'b0;
        funct         = opcode; // Branches carry their condition in funct.
        branch_target = branch_addr;
      end
      OP_REGIMM: begin
        if (rt_field == RI_BLTZ || rt_field == RI_BGEZ) begin
          is_branch     = 1'b1;
          use_imm       = 1'b0;
          funct         = {1'b0, rt_field};
          branch_target = branch_addr;
        end else begin
          exc_type = EXC_RI;
        end
      end
      OP_J, OP_JAL: begin
        is_jump        = 1'b1;
        branch_target  = jump_addr;
        imm_val        = '0;
        is_link        = (opcode == OP_JAL);
        reg_write_en   = (opcode == OP_JAL);
        reg_write_addr = 5'd31;
      end
      default: exc_type = EXC_RI;
    endcase
  end

endmodule

// ==== decode/reg_status_file.sv ====
`timescale 1ns/1ps

module reg_status_file
  import uarch_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rd_idx_1,
  input  reg_idx_t rd_idx_2,
  output logic     rd_is_ref_1,
  output logic     rd_is_ref_2,
  output word_t    rd_data_1,
  output word_t    rd_data_2,
  input  logic     ren_en,
  input  reg_idx_t ren_idx,
  input  rob_tag_t ren_tag,
  input  logic     commit_en,
  input  reg_idx_t commit_idx,
  input  rob_tag_t commit_tag,
  input  word_t    commit_data
);

  word_t       value_q [32];
  rob_tag_t    tag_q   [32];
  logic [31:0] ref_q;

  // Returns {is_ref, data}. A matching commit in this cycle bypasses into the read.
  function automatic logic [32:0] lookup(input reg_idx_t idx);
    logic hit;
    hit = commit_en && (commit_idx == idx) && (tag_q[idx] == commit_tag);
    if (idx == '0) begin
      lookup = {1'b0, 32'h0};
    end else if (!ref_q[idx]) begin
      lookup = {1'b0, value_q[idx]};
    end else if (hit) begin
      lookup = {1'b0, commit_data};
    end else begin
      lookup = {1'b1, word_t'(tag_q[idx])};
    end
  endfunction

  always_comb begin
    {rd_is_ref_1, rd_data_1} = lookup(rd_idx_1);
    {rd_is_ref_2, rd_data_2} = lookup(rd_idx_2);
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        value_q[i] <= '0;
        tag_q[i]   <= '0;
      end
      ref_q <= '0;
    end else begin
      if (commit_en && ref_q[commit_idx] && tag_q[commit_idx] == commit_tag) begin
        value_q[commit_idx] <= commit_data;
        ref_q[commit_idx]   <= 1'b0;
      end
      if (ren_en && ren_idx != '0) begin // Later assignment lets a rename override the commit.
        ref_q[ren_idx] <= 1'b1;
        tag_q[ren_idx] <= ren_tag;
      end
    end
  end

endmodule

// ==== src/decode_top.sv ====
`timescale 1ns/1ps

module decode_top
  import isa_pkg::*;
  import uarch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output logic       wb_cyc,
  output logic       wb_stb,
  output addr_t      wb_adr,
  input  word_t      wb_dat,
  input  logic       wb_ack,
  input  logic       redirect_en,
  input  addr_t      redirect_pc,
  input  logic       commit_en,
  input  rob_tag_t   commit_tag,
  input  reg_idx_t   commit_idx,
  input  word_t      commit_data,
  input  logic       rob_ready,
  output logic       rob_valid,
  output rob_tag_t   rob_tag,
  output addr_t      rob_pc,
  output logic [5:0] rob_funct,
  output logic [4:0] rob_shamt,
  output logic       rob_operand_is_ref_1,
  output logic       rob_operand_is_ref_2,
  output word_t      rob_operand_data_1,
  output word_t      rob_operand_data_2,
  output logic       rob_reg_write_en,
  output reg_idx_t   rob_reg_write_addr,
  output logic       rob_mem_read,
  output logic       rob_mem_write,
  output logic       rob_mem_sign_ext,
  output mem_sel_t   rob_mem_sel,
  output logic       rob_is_branch,
  output logic       rob_is_jump,
  output addr_t      rob_branch_target,
  output logic       rob_is_delayslot,
  output exc_type_e  rob_exc_type
);

  logic         fetch_valid;
  fetch_slot_t  fetch_in;
  logic         slot_free;
  logic         f_valid;
  fetch_slot_t  f_slot;
  logic         dec_ready;
  logic         dec_fire;
  logic         flush;
  logic         jump_or_branch;
  decode_slot_t dec_in;
  decode_slot_t dec_out;
  reg_idx_t     rs_idx;
  reg_idx_t     rt_idx;
  logic         rd_is_ref_1;
  logic         rd_is_ref_2;
  word_t        rd_data_1;
  word_t        rd_data_2;
  word_t        imm_val;
  logic         use_imm;
  logic         is_link;

  assign dec_fire       = f_valid && dec_ready;
  assign jump_or_branch = dec_in.is_branch || dec_in.is_jump;
  assign dec_in.pc      = f_slot.pc;

  assign dec_in.operand_is_ref_1 = is_link ? 1'b0 : rd_is_ref_1;
  assign dec_in.operand_data_1   = is_link ? f_slot.pc + 32'd8 : rd_data_1;
  assign dec_in.operand_is_ref_2 = use_imm ? 1'b0 : rd_is_ref_2;
  assign dec_in.operand_data_2   = use_imm ? imm_val : rd_data_2;

  inst_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .slot_free   (slot_free),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_adr      (wb_adr),
    .wb_dat      (wb_dat),
    .wb_ack      (wb_ack),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_in.pc),
    .fetch_word  (fetch_in.inst)
  );

  stage_reg #(.payload_t(fetch_slot_t)) u_fetch_reg (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .in_valid  (fetch_valid),
    .in_ready  (slot_free),
    .in_data   (fetch_in),
    .out_valid (f_valid),
    .out_ready (dec_ready),
    .out_data  (f_slot)
  );

  inst_decoder u_decoder (
    .pc             (f_slot.pc),
    .inst           (f_slot.inst),
    .rs_idx         (rs_idx),
    .rt_idx         (rt_idx),
    .funct          (dec_in.funct),
    .shamt          (dec_in.shamt),
    .reg_write_en   (dec_in.reg_write_en),
    .reg_write_addr (dec_in.reg_write_addr),
    .mem_read       (dec_in.mem_read),
    .mem_write      (dec_in.mem_write),
    .mem_sign_ext   (dec_in.mem_sign_ext),
    .mem_sel        (dec_in.mem_sel),
    .is_branch      (dec_in.is_branch),
    .is_jump        (dec_in.is_jump),
    .branch_target  (dec_in.branch_target),
    .exc_type       (dec_in.exc_type),
    .imm_val        (imm_val),
    .use_imm        (use_imm),
    .is_link        (is_link)
  );

  reg_status_file u_status (
    .clk         (clk),
    .rst         (rst),
    .rd_idx_1    (rs_idx),
    .rd_idx_2    (rt_idx),
    .rd_is_ref_1 (rd_is_ref_1),
    .rd_is_ref_2 (rd_is_ref_2),
    .rd_data_1   (rd_data_1),
    .rd_data_2   (rd_data_2),
    .ren_en      (dec_fire && dec_in.reg_write_en),
    .ren_idx     (dec_in.reg_write_addr),
    .ren_tag     (dec_in.tag),
    .commit_en   (commit_en),
    .commit_idx  (commit_idx),
    .commit_tag  (commit_tag),
    .commit_data (commit_data)
  );

  front_ctrl u_ctrl (
    .clk                   (clk),
    .rst                   (rst),
    .redirect_en           (redirect_en),
    .dec_fire              (dec_fire),
    .dec_is_jump_or_branch (jump_or_branch),
    .flush                 (flush),
    .alloc_tag             (dec_in.tag),
    .in_delayslot          (dec_in.is_delayslot)
  );

  stage_reg #(.payload_t(decode_slot_t)) u_decode_reg (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .in_valid  (f_valid),
    .in_ready  (dec_ready),
    .in_data   (dec_in),
    .out_valid (rob_valid),
    .out_ready (rob_ready),
    .out_data  (dec_out)
  );

  assign rob_tag              = dec_out.tag;
  assign rob_pc               = dec_out.pc;
  assign rob_funct            = dec_out.funct;
  assign rob_shamt            = dec_out.shamt;
  assign rob_operand_is_ref_1 = dec_out.operand_is_ref_1;
  assign rob_operand_is_ref_2 = dec_out.operand_is_ref_2;
  assign rob_operand_data_1   = dec_out.operand_data_1;
  assign rob_operand_data_2   = dec_out.operand_data_2;
  assign rob_reg_write_en     = dec_out.reg_write_en;
  assign rob_reg_write_addr   = dec_out.reg_write_addr;
  assign rob_mem_read         = dec_out.mem_read;
  assign rob_mem_write        = dec_out.mem_write;
  assign rob_mem_sign_ext     = dec_out.mem_sign_ext;
  assign rob_mem_sel          = dec_out.mem_sel;
  assign rob_is_branch        = dec_out.is_branch;
  assign rob_is_jump          = dec_out.is_jump;
  assign rob_branch_target    = dec_out.branch_target;
  assign rob_is_delayslot     = dec_out.is_delayslot;
  assign rob_exc_type         = dec_out.exc_type;

endmodule

// ==== sim/decode_tb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_tb
  import isa_pkg::*;
  import uarch_pkg::*;
();

  localparam int    NUM_XFERS  = 300;
  localparam int    PROG_WORDS = 1024;
  localparam addr_t BASE_PC    = `CFG_RESET_PC;

  logic       clk;
  logic       rst;
  logic       wb_cyc;
  logic       wb_stb;
  addr_t      wb_adr;
  word_t      wb_dat;
  logic       wb_ack;
  logic       redirect_en;
  addr_t      redirect_pc;
  logic       commit_en;
  rob_tag_t   commit_tag;
  reg_idx_t   commit_idx;
  word_t      commit_data;
  logic       rob_ready;
  logic       rob_valid;
  rob_tag_t   rob_tag;
  addr_t      rob_pc;
  logic [5:0] rob_funct;
  logic [4:0] rob_shamt;
  logic       rob_operand_is_ref_1;
  logic       rob_operand_is_ref_2;
  word_t      rob_operand_data_1;
  word_t      rob_operand_data_2;
  logic       rob_reg_write_en;
  reg_idx_t   rob_reg_write_addr;
  logic       rob_mem_read;
  logic       rob_mem_write;
  logic       rob_mem_sign_ext;
  mem_sel_t   rob_mem_sel;
  logic       rob_is_branch;
  logic       rob_is_jump;
  addr_t      rob_branch_target;
  logic       rob_is_delayslot;
  exc_type_e  rob_exc_type;

  logic [31:0]  lfsr;
  word_t        prog [PROG_WORDS];
  word_t        mdl_val [32];
  rob_tag_t     mdl_tag [32];
  logic         mdl_ref [32];
  decode_slot_t exp_q [$];
  addr_t        exp_pc;
  rob_tag_t     exp_tag;
  logic         prev_jb;
  logic         prev_valid;
  logic         prev_xfer;
  logic         c_en;
  reg_idx_t     c_idx;
  rob_tag_t     c_tag;
  word_t        c_data;
  int           xfer_count;
  int           n_redirect;
  int           n_ref;
  int           n_delay;

  decode_top decode_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR stepped once for each bit taken.
  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 32'h80200003;
      r = {r[30:0], lsb};
    end
    return r;
  endfunction

  function automatic word_t word_at(input addr_t adr);
    return prog[adr[11:2]];
  endfunction

  function automatic reg_idx_t small_reg();
    return {2'b00, 3'(rand_bits(3))};
  endfunction

  task automatic build_program();
    logic [4:0]  kind;
    logic [5:0]  fn;
    logic [5:0]  op;
    logic [15:0] imm;
    for (int i = 0; i < PROG_WORDS; i++) begin
      kind = 5'(rand_bits(5));
      imm  = 16'(rand_bits(16));
      case (kind)
        5'd0: fn = 6'h20;
        5'd1: fn = 6'h21;
        5'd2: fn = 6'h22;
        5'd3: fn = 6'h23;
        5'd4: fn = 6'h24;
        5'd5: fn = 6'h25;
        5'd6: fn = 6'h26;
        5'd7: fn = 6'h27;
        5'd8: fn = 6'h2a;
        5'd9: fn = 6'h2b;
        5'd10: fn = 6'h00;
        5'd11: fn = 6'h02;
        5'd12: fn = 6'h03;
        5'd13: fn = 6'h08;
        5'd14: fn = 6'h09;
        5'd15: fn = 6'h0c;
        default: fn = 6'h01; // Not a defined funct.
      endcase
      case (kind)
        5'd16: op = 6'h08;
        5'd17: op = 6'h09;
        5'd18: op = 6'h0a;
        5'd19: op = 6'h0b;
        5'd20: op = 6'h0c;
        5'd21: op = 6'h0d;
        5'd22: op = 6'h0e;
        5'd23: op = 6'h0f;
        5'd24: op = {3'b100, 3'(rand_bits(3))};
        5'd25: op = {4'b1010, 2'(rand_bits(2))};
        5'd26: op = {4'b0001, 2'(rand_bits(2))};
        5'd28: op = {5'b00001, 1'(rand_bits(1))};
        5'd29: op = 6'h3f;
        default: op = 6'h01;
      endcase
      if (op == 6'h22 || op == 6'h2a) op = op + 6'h01; // No lwl or swl in the supported set.
      if (kind <= 5'd15 || kind == 5'd30) begin
        prog[i] = {6'h00, small_reg(), small_reg(), small_reg(), 5'(rand_bits(5)), fn};
      end else if (kind == 5'd27) begin
        prog[i] = {6'h01, small_reg(), 4'b0000, 1'(rand_bits(1)), imm};
      end else if (kind == 5'd31) begin
        prog[i] = {6'h01, small_reg(), 5'h02, imm};
      end else if (kind == 5'd28) begin
        prog[i] = {op, 26'(rand_bits(26))};
      end else begin
        prog[i] = {op, small_reg(), small_reg(), imm};
      end
    end
  endtask

  function automatic logic [32:0] model_read(input reg_idx_t idx);
    if (idx == 5'd0) return {1'b0, 32'h0};
    if (!mdl_ref[idx]) return {1'b0, mdl_val[idx]};
    if (c_en && c_idx == idx && c_tag == mdl_tag[idx]) return {1'b0, c_data};
    return {1'b1, word_t'(mdl_tag[idx])};
  endfunction

  // Reference MIPS32 decode against the model register state.
  function automatic decode_slot_t expect_slot(input addr_t pc, input word_t inst);
    decode_slot_t e;
    logic [5:0]   op;
    logic [5:0]   fn;
    reg_idx_t     rt;
    reg_idx_t     src2;
    word_t        sext;
    word_t        imm;
    logic         use_imm;
    logic         link;
    op   = inst[31:26];
    fn   = inst[5:0];
    rt   = inst[20:16];
    src2 = rt;
    sext = {{16{inst[15]}}, inst[15:0]};
    imm  = sext;
    use_imm = 1'b1;
    link    = 1'b0;
    e = '0;
    e.pc = pc;
    e.funct = 6'h21;
    e.reg_write_addr = rt;
    e.exc_type = EXC_NONE;
    case (op)
      6'h00: begin
        use_imm = 1'b0;
        e.funct = fn;
        e.shamt = inst[10:6];
        e.reg_write_addr = inst[15:11];
        case (fn)
          6'h00, 6'h02, 6'h03, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
          6'h2a, 6'h2b: e.reg_write_en = 1'b1;
          6'h08: e.is_jump = 1'b1;
          6'h09: begin
            e.is_jump = 1'b1;
            e.reg_write_en = 1'b1;
            link = 1'b1;
            src2 = inst[25:21];
          end
          6'h0c: e.exc_type = EXC_SYSCALL;
          default: e.exc_type = EXC_RI;
        endcase
      end
      6'h08, 6'h09, 6'h0a, 6'h0b: begin
        e.reg_write_en = 1'b1;
        e.funct = (op == 6'h08) ? 6'h20 : (op == 6'h09) ? 6'h21 : (op == 6'h0a) ? 6'h2a : 6'h2b;
      end
      6'h0c, 6'h0d, 6'h0e: begin
        e.reg_write_en = 1'b1;
        imm = {16'h0, inst[15:0]};
        e.funct = (op == 6'h0c) ? 6'h24 : (op == 6'h0d) ? 6'h25 : 6'h26;
      end
      6'h0f: begin
        e.reg_write_en = 1'b1;
        e.funct = 6'h25;
        imm = {inst[15:0], 16'h0};
      end
      6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
        e.reg_write_en = 1'b1;
        e.mem_read = 1'b1;
        e.mem_sign_ext = (op == 6'h20) || (op == 6'h21);
        e.mem_sel = (op == 6'h23) ? 4'b1111 : (op == 6'h21 || op == 6'h25) ? 4'b0011 : 4'b0001;
      end
      6'h28, 6'h29, 6'h2b: begin
        e.mem_write = 1'b1;
        e.mem_sel = (op == 6'h2b) ? 4'b1111 : (op == 6'h29) ? 4'b0011 : 4'b0001;
        use_imm = 1'b0;
        e.branch_target = sext;
      end
      6'h04, 6'h05, 6'h06, 6'h07: begin
        e.is_branch = 1'b1;
        use_imm = 1'b0;
        e.funct = op;
        e.branch_target = pc + 32'd4 + {sext[29:0], 2'b00};
      end
      6'h01: begin
        if (rt == 5'd0 || rt == 5'd1) begin
          e.is_branch = 1'b1;
          use_imm = 1'b0;
          e.funct = {1'b0, rt};
          e.branch_target = pc + 32'd4 + {sext[29:0], 2'b00};
        end else begin
          e.exc_type = EXC_RI;
        end
      end
      6'h02, 6'h03: begin
        e.is_jump = 1'b1;
        e.branch_target = {pc[31:28], inst[25:0], 2'b00};
        imm = '0;
        link = (op == 6'h03);
        e.reg_write_en = (op == 6'h03);
        e.reg_write_addr = 5'd31;
      end
      default: e.exc_type = EXC_RI;
    endcase
    if (link) {e.operand_is_ref_1, e.operand_data_1} = {1'b0, pc + 32'd8};
    else {e.operand_is_ref_1, e.operand_data_1} = model_read(inst[25:21]);
    if (use_imm) {e.operand_is_ref_2, e.operand_data_2} = {1'b0, imm};
    else {e.operand_is_ref_2, e.operand_data_2} = model_read(src2);
    return e;
  endfunction

  task automatic report_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_funct(input logic [5:0] got, input logic [5:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: funct is %h, expected %h", $time, got, exp);
      report_failure();
    end
  endtask

  task automatic check_sel(input mem_sel_t got, input mem_sel_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: mem_sel is %b, expected %b", $time, got, exp);
      report_failure();
    end
  endtask

  task automatic check_exc(input exc_type_e got, input exc_type_e exp);
    if (got !== exp) begin
      $display("mismatch at %0t: exc_type is %0d, expected %0d", $time, got, exp);
      report_failure();
    end
  endtask

  task automatic check_transfer(input decode_slot_t e);
    check_tag("tag", rob_tag, e.tag);
    check_word("pc", rob_pc, e.pc);
    check_funct(rob_funct, e.funct);
    check_idx("shamt", rob_shamt, e.shamt);
    check_flag("operand_is_ref_1", rob_operand_is_ref_1, e.operand_is_ref_1);
    check_flag("operand_is_ref_2", rob_operand_is_ref_2, e.operand_is_ref_2);
    check_word("operand_data_1", rob_operand_data_1, e.operand_data_1);
    check_word("operand_data_2", rob_operand_data_2, e.operand_data_2);
    check_flag("reg_write_en", rob_reg_write_en, e.reg_write_en);
    check_idx("reg_write_addr", rob_reg_write_addr, e.reg_write_addr);
    check_flag("mem_read", rob_mem_read, e.mem_read);
    check_flag("mem_write", rob_mem_write, e.mem_write);
    check_flag("mem_sign_ext", rob_mem_sign_ext, e.mem_sign_ext);
    check_sel(rob_mem_sel, e.mem_sel);
    check_flag("is_branch", rob_is_branch, e.is_branch);
    check_flag("is_jump", rob_is_jump, e.is_jump);
    check_word("branch_target", rob_branch_target, e.branch_target);
    check_flag("is_delayslot", rob_is_delayslot, e.is_delayslot);
    check_exc(rob_exc_type, e.exc_type);
  endtask

  // Drives the Wishbone memory, ROB back-pressure, commits and redirects.
  always @(posedge clk) begin
    reg_idx_t idx;
    logic     redir;
    if (!rst) begin
      wb_ack      <= 1'b0;
      rob_ready   <= 1'b0;
      commit_en   <= 1'b0;
      redirect_en <= 1'b0;
    end else begin
      if (wb_stb !== wb_cyc) begin
        $display("Wishbone strobe does not follow the cycle signal at %0t", $time);
        report_failure();
      end
      if (wb_cyc && wb_adr[31:12] != BASE_PC[31:12]) begin
        $display("fetch address %h is outside the program window", wb_adr);
        report_failure();
      end
      if (wb_ack) begin
        wb_ack <= 1'b0;
      end else if (wb_cyc && wb_stb && rand_bits(1) != 0) begin
        wb_ack <= 1'b1;
        wb_dat <= word_at(wb_adr);
      end
      redir = (rand_bits(6) == 0);
      redirect_en <= redir;
      if (redir) redirect_pc <= BASE_PC + {22'h0, 8'(rand_bits(8)), 2'b00};
      rob_ready <= redir ? 1'b0 : (rand_bits(2) != 0); // No transfer in a redirect cycle.
      idx = small_reg();
      commit_en   <= 1'(rand_bits(1));
      commit_idx  <= idx;
      commit_tag  <= (rand_bits(1) != 0) ? mdl_tag[idx] : rob_tag_t'(rand_bits(4));
      commit_data <= rand_bits(32);
    end
  end

  // Model and comparison. A new entry seen now was decoded in the previous cycle.
  always @(negedge clk) begin
    decode_slot_t e;
    logic         fired;
    if (!rst) begin
      prev_valid = 1'b0;
      prev_xfer  = 1'b0;
    end else begin
      fired = 1'b0;
      if (rob_valid && (!prev_valid || prev_xfer)) begin
        e = expect_slot(exp_pc, word_at(exp_pc));
        e.tag = exp_tag;
        e.is_delayslot = prev_jb;
        exp_q.push_back(e);
        exp_tag = (exp_tag == rob_tag_t'(`CFG_ROB_DEPTH - 1)) ? '0 : exp_tag + 4'd1;
        prev_jb = e.is_branch || e.is_jump;
        exp_pc = exp_pc + 32'd4;
        fired = 1'b1;
      end
      if (c_en && mdl_ref[c_idx] && mdl_tag[c_idx] == c_tag) begin
        mdl_val[c_idx] = c_data;
        mdl_ref[c_idx] = 1'b0;
      end
      if (fired && e.reg_write_en && e.reg_write_addr != 5'd0) begin
        mdl_ref[e.reg_write_addr] = 1'b1;
        mdl_tag[e.reg_write_addr] = e.tag;
      end
      if (rob_valid && rob_ready) begin
        if (exp_q.size() == 0) begin
          $display("ROB transfer at %0t with no decoded instruction expected", $time);
          report_failure();
        end
        e = exp_q.pop_front();
        check_transfer(e);
        xfer_count++;
        if (e.operand_is_ref_1 || e.operand_is_ref_2) n_ref++;
        if (e.is_delayslot) n_delay++;
      end
      if (redirect_en) begin
        exp_q.delete();
        exp_pc = redirect_pc;
        prev_jb = 1'b0;
        n_redirect++;
      end
      prev_valid = rob_valid;
      prev_xfer  = rob_valid && rob_ready;
    end
    c_en   = commit_en;
    c_idx  = commit_idx;
    c_tag  = commit_tag;
    c_data = commit_data;
  end

  initial begin
    #(NUM_XFERS * 40 * 20);
    $display("watchdog expired after %0d of %0d ROB transfers", xfer_count, NUM_XFERS);
    report_failure();
  end

  initial begin
    lfsr = 32'h713a;
    rst = 1'b0;
    wb_dat = '0;
    wb_ack = 1'b0;
    redirect_en = 1'b0;
    redirect_pc = '0;
    commit_en = 1'b0;
    commit_tag = '0;
    commit_idx = '0;
    commit_data = '0;
    rob_ready = 1'b0;
    exp_pc = BASE_PC;
    exp_tag = '0;
    prev_jb = 1'b0;
    xfer_count = 0;
    n_redirect = 0;
    n_ref = 0;
    n_delay = 0;
    for (int i = 0; i < 32; i++) begin
      mdl_val[i] = '0;
      mdl_tag[i] = '0;
      mdl_ref[i] = 1'b0;
    end
    build_program();
    repeat (4) @(posedge clk);
    rst <= 1'b1;
    while (xfer_count < NUM_XFERS) @(posedge clk);
    if (n_redirect > 0 && n_ref > 0 && n_delay > 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("stimulus missed redirects, references or delay slots");
      report_failure();
    end
  end

endmodule

// ==== sources.f ====
+incdir+common
common/isa_pkg.sv
common/uarch_pkg.sv
src/inst_fetch.sv
src/stage_reg.sv
src/front_ctrl.sv
decode/inst_decoder.sv
decode/reg_status_file.sv
src/decode_top.sv
sim/decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the decode testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module decode_tb -o decode_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/decode_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
